// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert -f sources.f --top-module fedp_tb -Mdir obj_dir
	./obj_dir/Vfedp_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/fedp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_properties (
    input logic        clk,
    input logic        arst_n,
    input logic        enable,
    input logic        fmt,
    input logic [31:0] d_val
);

    // a stalled edge leaves the output alone
    assert property (@(posedge clk) disable iff (!arst_n) !enable |=> $stable(d_val))
        else $error("d_val changed after a stalled cycle");

    assert property (@(posedge clk) disable iff (!arst_n) enable |-> !$isunknown(fmt))
        else $error("fmt unknown on an enabled cycle");

    assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(d_val))
        else $error("d_val unknown after reset");

endmodule

bind fedp_top fedp_properties u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .enable (enable),
    .fmt    (fmt),
    .d_val  (d_val)
);

`default_nettype wire

// File: dv/fedp_model.svh
`ifndef FEDP_MODEL_SVH
`define FEDP_MODEL_SVH
`default_nettype none

logic [31:0] rng_state;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// position of the highest set bit or -1 for zero
function automatic int msb64(input logic [63:0] v);
    int p;
    p = -1;
    for (int i = 0; i < 64; i++) begin
        if (v[i]) begin
            p = i;
        end
    end
    return p;
endfunction

function automatic logic [15:0] make_elem(input logic f, input logic s, input logic [7:0] e,
                                          input logic [9:0] fr);
    fedp_pkg::elem_u u;
    u = '0;
    if (f == fedp_pkg::FMT_FP16) begin
        u.fp16.sign = s;
        u.fp16.exp  = e[4:0];
        u.fp16.frac = fr;
    end else begin
        u.bf16.sign = s;
        u.bf16.exp  = e;
        u.bf16.frac = fr[6:0];
    end
    return u;
endfunction

function automatic logic [15:0] fp16_of_int(input int v);
    int          m;
    int          p;
    logic [63:0] w;
    if (v == 0) begin
        return 16'd0;
    end
    m = (v < 0) ? -v : v;
    p = msb64(64'(m));
    w = 64'(m) << (10 - p);
    return make_elem(fedp_pkg::FMT_FP16, v < 0, 8'(15 + p), w[9:0]);
endfunction

function automatic logic [31:0] fp32_of_int(input int v);
    int          m;
    int          p;
    logic [63:0] w;
    if (v == 0) begin
        return 32'd0;
    end
    m = (v < 0) ? -v : v;
    p = msb64(64'(m));
    w = 64'(m) << (23 - p);
    return {v < 0, 8'(127 + p), w[22:0]};
endfunction

// random normal element with exponent near one so products stay in range
function automatic logic [15:0] rand_elem(input logic f);
    logic [31:0] r;
    logic [7:0]  e;
    r = next_rand();
    if (f == fedp_pkg::FMT_FP16) begin
        e = 8'd8 + {4'd0, r[11:8] % 4'd15};
    end else begin
        e = 8'd110 + {3'd0, r[12:8]};
    end
    return make_elem(f, r[0], e, r[21:12]);
endfunction

function automatic logic [63:0] rand_vec(input logic f);
    logic [63:0] v;
    for (int l = 0; l < fedp_pkg::LANES; l++) begin
        v[16*l +: 16] = rand_elem(f);
    end
    return v;
endfunction

function automatic logic [31:0] rand_c();
    logic [31:0] r;
    r = next_rand();
    return {r[0], 8'd112 + {3'd0, r[5:1]}, r[28:6]};
endfunction

// exact lane product as single precision
function automatic logic [31:0] elem_prod(input logic f, input logic [15:0] x,
                                          input logic [15:0] y);
    int          fb;
    int          bias;
    int          ex;
    int          ey;
    int          p;
    int          e;
    logic [10:0] mx;
    logic [10:0] my;
    logic [21:0] m;
    logic [63:0] w;
    logic        s;
    fb   = (f == fedp_pkg::FMT_FP16) ? 10 : 7;
    bias = (f == fedp_pkg::FMT_FP16) ? 15 : 127;
    ex   = (f == fedp_pkg::FMT_FP16) ? int'(x[14:10]) : int'(x[14:7]);
    ey   = (f == fedp_pkg::FMT_FP16) ? int'(y[14:10]) : int'(y[14:7]);
    if (ex == 0 || ey == 0) begin
        return 32'd0;  // zero or subnormal element
    end
    mx = (f == fedp_pkg::FMT_FP16) ? {1'b1, x[9:0]} : {3'd0, 1'b1, x[6:0]};
    my = (f == fedp_pkg::FMT_FP16) ? {1'b1, y[9:0]} : {3'd0, 1'b1, y[6:0]};
    m  = mx * my;
    p  = msb64(64'(m));
    e  = (ex - bias) + (ey - bias) + p - 2 * fb + 127;
    s  = x[15] ^ y[15];
    if (e >= 255) begin
        return {s, 8'hfe, 23'h7fffff};
    end
    if (e <= 0) begin
        return 32'd0;
    end
    w = 64'(m) << (23 - p);
    return {s, e[7:0], w[22:0]};
endfunction

// exact sum and then one rounding to nearest even
function automatic logic [31:0] fp32_add_ref(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] t;
    logic [63:0] ma;
    logic [63:0] mb;
    logic [63:0] m;
    logic [63:0] keep;
    logic [63:0] rem;
    logic [63:0] half;
    logic        s;
    int          ea;
    int          eb;
    int          d;
    int          p;
    int          sh;
    int          e;
    if (b[30:23] > a[30:23]) begin
        t = a;
        a = b;
        b = t;
    end
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    if (ea == 0) begin
        return 32'd0;
    end
    if (eb == 0) begin
        return a;
    end
    d = ea - eb;
    if (d > 26) begin
        return a;  // small one is below a quarter ulp
    end
    ma = {40'd0, 1'b1, a[22:0]} << d;
    mb = {40'd0, 1'b1, b[22:0]};
    if (a[31] == b[31]) begin
        m = ma + mb;
        s = a[31];
    end else if (ma >= mb) begin
        m = ma - mb;
        s = a[31];
    end else begin
        m = mb - ma;
        s = b[31];
    end
    if (m == 64'd0) begin
        return 32'd0;
    end
    p = msb64(m);
    e = eb + p - 23;
    if (p > 23) begin
        sh   = p - 23;
        keep = m >> sh;
        rem  = m & ((64'd1 << sh) - 64'd1);
        half = 64'd1 << (sh - 1);
        if (rem > half || (rem == half && keep[0])) begin
            keep = keep + 64'd1;
        end
        if (keep[24]) begin
            keep = keep >> 1;
            e    = e + 1;
        end
    end else begin
        keep = m << (23 - p);
    end
    if (e >= 255) begin
        return {s, 8'hff, 23'd0};
    end
    if (e <= 0) begin
        return 32'd0;  // ftz
    end
    return {s, e[7:0], keep[22:0]};
endfunction

function automatic logic [31:0] fedp_ref(input logic f, input logic [63:0] a,
                                         input logic [63:0] b, input logic [31:0] c);
    logic [31:0] p [4];
    logic [31:0] s01;
    logic [31:0] s23;
    for (int l = 0; l < 4; l++) begin
        p[l] = elem_prod(f, a[16*l +: 16], b[16*l +: 16]);
    end
    s01 = fp32_add_ref(p[0], p[1]);
    s23 = fp32_add_ref(p[2], p[3]);
    return fp32_add_ref(c, fp32_add_ref(s01, s23));
endfunction

`default_nettype wire
`endif

// File: dv/fedp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_tb;

    localparam int N_DIRECT    = 4;
    localparam int N_RANDOM    = 40;
    localparam int N_ZERO      = 4;
    localparam int N_STALL     = 16;
    localparam int N_VECTORS   = N_DIRECT + N_RANDOM + N_ZERO + N_STALL;
    localparam int CYCLE_LIMIT = 2 * N_VECTORS + fedp_pkg::TOTAL_LAT + 50;

    logic        clk;
    logic        arst_n;
    logic        enable;
    logic        fmt;
    logic [63:0] a_row;
    logic [63:0] b_col;
    logic [31:0] c_val;
    logic [31:0] d_val;

    logic [31:0] exp_q [$];   // expected results in arrival order
    int          idx_q [$];   // enabled edges seen before each input was sampled
    string       name_q [$];
    string       test_name;
    logic        track;
    logic        last_en;
    logic [31:0] prev_d;
    int          en_count;
    int          mismatches;
    int          other_errors;
    int          cycles;

    `include "fedp_model.svh"

    fedp_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (enable),
        .fmt    (fmt),
        .a_row  (a_row),
        .b_col  (b_col),
        .c_val  (c_val),
        .d_val  (d_val)
    );

    always #10 clk = ~clk;

    task automatic check_result(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_hold(input string name, input logic [31:0] held,
                              input logic [31:0] actual);
        if (actual !== held) begin
            mismatches++;
            $display("Mismatch %s (stall): expected %08h actual %08h", name, held, actual);
        end
    endtask

    task automatic send(input string name, input logic f, input logic [63:0] a,
                        input logic [63:0] b, input logic [31:0] c);
        @(posedge clk);
        test_name <= name;
        track     <= 1'b1;
        enable    <= 1'b1;
        fmt       <= f;
        a_row     <= a;
        b_col     <= b;
        c_val     <= c;
    endtask

    task automatic stall(input int n);
        @(posedge clk);
        enable <= 1'b0;
        track  <= 1'b0;
        repeat (n - 1) @(posedge clk);
    endtask

    function automatic logic [63:0] int_vec(input int e0, input int e1, input int e2,
                                            input int e3);
        return {fp16_of_int(e3), fp16_of_int(e2), fp16_of_int(e1), fp16_of_int(e0)};
    endfunction

    // reference model sees inputs as the DUT samples them
    always @(posedge clk) begin
        last_en = enable && arst_n;
        if (arst_n && enable) begin
            if (track) begin
                exp_q.push_back(fedp_ref(fmt, a_row, b_col, c_val));
                idx_q.push_back(en_count);
                name_q.push_back(test_name);
            end
            en_count++;
        end
    end

    // compare on the falling edge where d_val is stable
    always @(negedge clk) begin
        if (arst_n) begin
            if (!last_en) begin
                check_hold(test_name, prev_d, d_val);
            end else if (idx_q.size() > 0 && idx_q[0] + fedp_pkg::TOTAL_LAT == en_count) begin
                check_result(name_q.pop_front(), exp_q.pop_front(), d_val);
                void'(idx_q.pop_front());
            end
        end
        prev_d = d_val;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [63:0] sub_vec;
        clk          = 1'b0;
        arst_n       = 1'b0;
        enable       = 1'b0;
        fmt          = fedp_pkg::FMT_FP16;
        a_row        = 64'd0;
        b_col        = 64'd0;
        c_val        = 32'd0;
        track        = 1'b0;
        last_en      = 1'b0;
        prev_d       = 32'd0;
        test_name    = "reset";
        en_count     = 0;
        mismatches   = 0;
        other_errors = 0;
        cycles       = 0;
        rng_state    = 32'd22;

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_result("reset", 32'd0, d_val);

        // small integers give exact results
        send("fp16_int_a", fedp_pkg::FMT_FP16, int_vec(1, 2, 3, 4), int_vec(5, 6, 7, 8),
             fp32_of_int(10));
        send("fp16_int_b", fedp_pkg::FMT_FP16, int_vec(-3, 2, 0, 7), int_vec(4, -5, 9, 1),
             fp32_of_int(-2));
        send("fp16_int_c", fedp_pkg::FMT_FP16, int_vec(16, 16, 16, 16), int_vec(8, 8, 8, 8),
             fp32_of_int(1000));
        send("fp16_int_d", fedp_pkg::FMT_FP16, int_vec(0, 0, 0, 0), int_vec(3, 3, 3, 3),
             fp32_of_int(-77));

        for (int i = 0; i < N_RANDOM; i++) begin
            if (i % 2 == 0) begin
                send("random_fp16", fedp_pkg::FMT_FP16, rand_vec(fedp_pkg::FMT_FP16),
                     rand_vec(fedp_pkg::FMT_FP16), rand_c());
            end else begin
                send("random_bf16", fedp_pkg::FMT_BF16, rand_vec(fedp_pkg::FMT_BF16),
                     rand_vec(fedp_pkg::FMT_BF16), rand_c());
            end
        end

        // subnormals in lanes 1 and 3 behave like zeros
        sub_vec = int_vec(3, 0, 5, 0);
        sub_vec[31:16] = make_elem(fedp_pkg::FMT_FP16, 1'b0, 8'd0, 10'h155);
        sub_vec[63:48] = make_elem(fedp_pkg::FMT_FP16, 1'b1, 8'd0, 10'h3ff);
        send("subnormal", fedp_pkg::FMT_FP16, sub_vec, int_vec(2, 9, 2, 9), fp32_of_int(1));
        send("subnormal_zero", fedp_pkg::FMT_FP16, int_vec(3, 0, 5, 0), int_vec(2, 9, 2, 9),
             fp32_of_int(1));
        send("cancel_fp16", fedp_pkg::FMT_FP16, int_vec(1, 2, 3, 0), int_vec(2, 2, 1, 0),
             fp32_of_int(-9));
        send("cancel_bf16", fedp_pkg::FMT_BF16,
             {make_elem(fedp_pkg::FMT_BF16, 1'b0, 8'd128, 10'd0), 48'd0},
             64'h4000_0000_0000_0000, 32'hc080_0000);

        // random stalls between vectors
        for (int i = 0; i < N_STALL; i++) begin
            send("stall_flow", i[0], rand_vec(i[0]), rand_vec(i[0]), rand_c());
            if (next_rand() % 2 == 0) begin
                stall(1 + int'(next_rand() % 3));
            end
        end

        // drain the pipeline
        @(posedge clk);
        track  <= 1'b0;
        enable <= 1'b1;
        repeat (fedp_pkg::TOTAL_LAT) @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(negedge clk);

        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected results never appeared on d_val", exp_q.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+dv
verilog/fedp_pkg.sv
verilog/fedp_unpack.sv
verilog/fedp_mul.sv
verilog/fp32_add.sv
verilog/fedp_reduce.sv
verilog/fedp_accum.sv
verilog/fedp_top.sv
dv/fedp_properties.sv
dv/fedp_tb.sv

// File: verilog/fedp_accum.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_accum (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        enable,
    input  logic [31:0] c_val,
    input  logic [31:0] tree_sum,
    output logic [31:0] d_val
);

    // c_val delay line, stage 0 is loaded on the input edge
    logic [31:0] c_pipe [fedp_pkg::C_DELAY];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < fedp_pkg::C_DELAY; i++) begin
                c_pipe[i] <= 32'd0;
            end
        end else if (enable) begin
            c_pipe[0] <= c_val;
            for (int i = 1; i < fedp_pkg::C_DELAY; i++) begin
                c_pipe[i] <= c_pipe[i-1];
            end
        end
    end

    fp32_add u_final (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (enable),
        .a      (c_pipe[fedp_pkg::C_DELAY-1]),   // c first, then the tree
        .b      (tree_sum),
        .y      (d_val)
    );

endmodule

`default_nettype wire

// File: verilog/fedp_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_mul (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        enable,
    input  logic        a_sign,
    input  logic        b_sign,
    input  logic [8:0]  a_exp,
    input  logic [8:0]  b_exp,
    input  logic [10:0] a_sig,
    input  logic [10:0] b_sig,
    output logic [31:0] prod
);

    logic [21:0]        sig_p;   // 1.x * 1.x, msb at bit 21 or 20
    logic signed [10:0] exp_sum;
    logic signed [10:0] exp_b;   // biased fp32 exponent
    logic [22:0]        frac;
    logic               sign_p;
    logic [31:0]        prod_d;

    assign sig_p   = a_sig * b_sig;
    assign sign_p  = a_sign ^ b_sign;
    assign exp_sum = $signed({{2{a_exp[8]}}, a_exp}) + $signed({{2{b_exp[8]}}, b_exp});

    always_comb begin
        // at most one bit of normalization, all product bits fit in 23
        if (sig_p[21]) begin
            frac  = {sig_p[20:0], 2'b00};
            exp_b = exp_sum + 11'sd128;
        end else begin
            frac  = {sig_p[19:0], 3'b000};
            exp_b = exp_sum + 11'sd127;
        end

        if (sig_p == 22'd0) begin
            prod_d = 32'd0;                            // zero operand
        end else if (exp_b >= 11'sd255) begin
            prod_d = {sign_p, 8'hfe, 23'h7fffff};      // clamp to max finite
        end else if (exp_b <= 11'sd0) begin
            prod_d = 32'd0;                            // below fp32 normal range
        end else begin
            prod_d = {sign_p, exp_b[7:0], frac};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod <= 32'd0;
        end else if (enable) begin
            prod <= prod_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fedp_pkg.sv
`default_nettype none

package fedp_pkg;

    // operand geometry
    localparam int N_WORDS = 2;                  // 32-bit words per operand vector
    localparam int LANES   = 2 * N_WORDS;        // 16-bit elements per vector
    localparam int LEVELS  = 2;                  // adder tree depth for four lanes

    // pipeline latencies, in enabled cycles
    localparam int MUL_LAT   = 1;
    localparam int ADD_LAT   = 1;
    localparam int C_DELAY   = MUL_LAT + LEVELS * ADD_LAT;   // c_val meets tree_sum
    localparam int TOTAL_LAT = C_DELAY + ADD_LAT;            // input edge to d_val

    // element format select
    localparam logic FMT_FP16 = 1'b0;
    localparam logic FMT_BF16 = 1'b1;

    // one 16-bit element, read either as half or as brain float
    // sign sits in bit 15 for both
    typedef union packed {
        struct packed {
            logic       sign;
            logic [4:0] exp;     // bias 15
            logic [9:0] frac;
        } fp16;
        struct packed {
            logic       sign;
            logic [7:0] exp;     // bias 127, same range as fp32
            logic [6:0] frac;
        } bf16;
    } elem_u;

endpackage

`default_nettype wire

// File: verilog/fedp_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_reduce (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       enable,
    input  logic [fedp_pkg::LANES-1:0] a_sign,
    input  logic [fedp_pkg::LANES-1:0] b_sign,
    input  logic [8:0]                 a_exp [fedp_pkg::LANES],
    input  logic [8:0]                 b_exp [fedp_pkg::LANES],
    input  logic [10:0]                a_sig [fedp_pkg::LANES],
    input  logic [10:0]                b_sig [fedp_pkg::LANES],
    output logic [31:0]                tree_sum
);

    logic [31:0] prod     [fedp_pkg::LANES];
    logic [31:0] pair_sum [fedp_pkg::LANES/2];

    for (genvar i = 0; i < fedp_pkg::LANES; i++) begin : g_lane
        fedp_mul u_mul (
            .clk    (clk),
            .arst_n (arst_n),
            .enable (enable),
            .a_sign (a_sign[i]),
            .b_sign (b_sign[i]),
            .a_exp  (a_exp[i]),
            .b_exp  (b_exp[i]),
            .a_sig  (a_sig[i]),
            .b_sig  (b_sig[i]),
            .prod   (prod[i])
        );
    end

    // first level, lanes (0,1) and (2,3)
    for (genvar i = 0; i < fedp_pkg::LANES / 2; i++) begin : g_pair
        fp32_add u_add (
            .clk    (clk),
            .arst_n (arst_n),
            .enable (enable),
            .a      (prod[2*i]),
            .b      (prod[2*i+1]),
            .y      (pair_sum[i])
        );
    end

    fp32_add u_root (
        .clk    (clk),
        .arst_n (arst_n),
        .enable (enable),
        .a      (pair_sum[0]),
        .b      (pair_sum[1]),
        .y      (tree_sum)
    );

endmodule

`default_nettype wire

// File: verilog/fedp_top.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            enable,
    input  logic                            fmt,
    input  logic [fedp_pkg::N_WORDS*32-1:0] a_row,
    input  logic [fedp_pkg::N_WORDS*32-1:0] b_col,
    input  logic [31:0]                     c_val,
    output logic [31:0]                     d_val
);

    // decoded lanes, combinational from the ports
    logic [fedp_pkg::LANES-1:0] a_sign;
    logic [fedp_pkg::LANES-1:0] b_sign;
    logic [8:0]                 a_exp [fedp_pkg::LANES];
    logic [8:0]                 b_exp [fedp_pkg::LANES];
    logic [10:0]                a_sig [fedp_pkg::LANES];
    logic [10:0]                b_sig [fedp_pkg::LANES];
    logic [31:0]                tree_sum;

    fedp_unpack u_unpack (
        .fmt    (fmt),
        .a_row  (a_row),
        .b_col  (b_col),
        .a_sign (a_sign),
        .b_sign (b_sign),
        .a_exp  (a_exp),
        .b_exp  (b_exp),
        .a_sig  (a_sig),
        .b_sig  (b_sig)
    );

    fedp_reduce u_reduce (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .a_sign   (a_sign),
        .b_sign   (b_sign),
        .a_exp    (a_exp),
        .b_exp    (b_exp),
        .a_sig    (a_sig),
        .b_sig    (b_sig),
        .tree_sum (tree_sum)
    );

    fedp_accum u_accum (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .c_val    (c_val),
        .tree_sum (tree_sum),
        .d_val    (d_val)
    );

endmodule

`default_nettype wire

// File: verilog/fedp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fedp_unpack (
    input  logic                              fmt,
    input  logic [fedp_pkg::N_WORDS*32-1:0]   a_row,
    input  logic [fedp_pkg::N_WORDS*32-1:0]   b_col,
    output logic [fedp_pkg::LANES-1:0]        a_sign,
    output logic [fedp_pkg::LANES-1:0]        b_sign,
    output logic [8:0]                        a_exp [fedp_pkg::LANES],
    output logic [8:0]                        b_exp [fedp_pkg::LANES],
    output logic [10:0]                       a_sig [fedp_pkg::LANES],
    output logic [10:0]                       b_sig [fedp_pkg::LANES]
);

    // returns {sign, unbiased exp, significand with hidden bit}
    function automatic logic [20:0] decode(input fedp_pkg::elem_u e, input logic f);
        logic        sign;
        logic [8:0]  exp_u;
        logic [10:0] sig;
        logic        is_zero;
        sign    = 1'b0;
        exp_u   = 9'd0;
        sig     = 11'd0;
        is_zero = 1'b1;
        case (f)
            fedp_pkg::FMT_FP16: begin
                sign    = e.fp16.sign;
                is_zero = (e.fp16.exp == 5'd0);
                exp_u   = {4'b0000, e.fp16.exp} - 9'd15;
                sig     = {1'b1, e.fp16.frac};
            end
            fedp_pkg::FMT_BF16: begin
                sign    = e.bf16.sign;
                is_zero = (e.bf16.exp == 8'd0);
                exp_u   = {1'b0, e.bf16.exp} - 9'd127;
                sig     = {1'b1, e.bf16.frac, 3'b000};  // left align to the fp16 width
            end
            default: ;
        endcase
        // subnormals read as zero
        if (is_zero) begin
            exp_u = 9'd0;
            sig   = 11'd0;
        end
        return {sign, exp_u, sig};
    endfunction

    // lane 2w is the low half of word w, lane 2w+1 the high half
    for (genvar w = 0; w < fedp_pkg::N_WORDS; w++) begin : g_word
        for (genvar h = 0; h < 2; h++) begin : g_half
            localparam int L = 2 * w + h;
            assign {a_sign[L], a_exp[L], a_sig[L]} = decode(a_row[32*w + 16*h +: 16], fmt);
            assign {b_sign[L], b_exp[L], b_sig[L]} = decode(b_col[32*w + 16*h +: 16], fmt);
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp32_add.sv
`timescale 1ns/1ps
`default_nettype none

module fp32_add (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        enable,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y
);

    logic              swap;
    logic [31:0]       big_w;
    logic [31:0]       sml_w;
    logic [7:0]        e_big;
    logic [23:0]       m_big;
    logic [23:0]       m_sml;
    logic [7:0]        e_diff;
    logic [4:0]        shamt;
    logic [50:0]       sml_sh;
    logic [26:0]       sml_al;   // 24 sig bits + guard, round, sticky
    logic [27:0]       sum;
    logic [4:0]        lz;
    logic [26:0]       norm;
    logic signed [9:0] exp_n;
    logic              rnd_up;
    logic [24:0]       mant;
    logic signed [9:0] exp_r;
    logic [22:0]       frac;
    logic [31:0]       y_d;

    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] n;
        n = 5'd27;
        for (int i = 0; i < 27; i++) begin
            if (v[i]) begin
                n = 5'(26 - i);  // highest set bit wins
            end
        end
        return n;
    endfunction

    // order by magnitude so the subtract never goes negative
    assign swap  = b[30:0] > a[30:0];
    assign big_w = swap ? b : a;
    assign sml_w = swap ? a : b;

    assign e_big = big_w[30:23];
    assign m_big = (e_big == 8'd0) ? 24'd0 : {1'b1, big_w[22:0]};   // flush subnormal input
    assign m_sml = (sml_w[30:23] == 8'd0) ? 24'd0 : {1'b1, sml_w[22:0]};

    assign e_diff = e_big - sml_w[30:23];
    assign shamt  = (e_diff > 8'd27) ? 5'd27 : e_diff[4:0];

    // alignment, everything shifted past the round bit folds into sticky
    assign sml_sh = {m_sml, 27'd0} >> shamt;
    assign sml_al = {sml_sh[50:25], sml_sh[24] | (|sml_sh[23:0])};

    assign sum = (big_w[31] == sml_w[31]) ? {1'b0, m_big, 3'b000} + {1'b0, sml_al}
                                          : {1'b0, m_big, 3'b000} - {1'b0, sml_al};

    assign lz = lzc27(sum[26:0]);

    always_comb begin
        if (sum[27]) begin
            // carry out, shift right and keep sticky
            norm  = {sum[27:2], sum[1] | sum[0]};
            exp_n = $signed({2'b00, e_big}) + 10'sd1;
        end else begin
            norm  = sum[26:0] << lz;
            exp_n = $signed({2'b00, e_big}) - $signed({5'b00000, lz});
        end

        // round to nearest, ties to even
        rnd_up = norm[2] & (norm[1] | norm[0] | norm[3]);
        mant   = {1'b0, norm[26:3]} + {24'd0, rnd_up};
        exp_r  = mant[24] ? exp_n + 10'sd1 : exp_n;
        frac   = mant[24] ? mant[23:1] : mant[22:0];

        if (sum == 28'd0) begin
            y_d = 32'd0;                          // exact cancellation is +0
        end else if (exp_r >= 10'sd255) begin
            y_d = {big_w[31], 8'hff, 23'd0};      // overflow to inf
        end else if (exp_r <= 10'sd0) begin
            y_d = 32'd0;                          // ftz
        end else begin
            y_d = {big_w[31], exp_r[7:0], frac};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y <= 32'd0;
        end else if (enable) begin
            y <= y_d;
        end
    end

endmodule

`default_nettype wire
